/* logic/sram_params.svh */
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// word address width of both SRAM chips
`define SRAM_ADDR_W 20

`define WORD_W 32 // data word width
`define BE_W 4 // byte lanes per word

// virtual address width seen by the execute stage
`define CPU_ADDR_W 32

// upper 24 address bits of the memory-mapped I/O page at 0xBFD003xx
`define IO_PAGE 24'hBFD003

`endif

/* logic/mem_op_pkg.sv */
`include "sram_params.svh"

package mem_op_pkg;

	// memory operation carried down the pipeline
	typedef enum logic [3:0] {
		NOP = 4'd0,
		LB  = 4'd1,
		LBU = 4'd2,
		LH  = 4'd3,
		LHU = 4'd4,
		LW  = 4'd5,
		SB  = 4'd6,
		SH  = 4'd7,
		SW  = 4'd8
	} mem_op_t;

	// byte offset inside a word
	typedef logic [$clog2(`BE_W)-1:0] byte_sel_t;

	typedef logic [`WORD_W-1:0] word_t; // one data word

endpackage

/* logic/sram_bus_pkg.sv */
`include "sram_params.svh"

package sram_bus_pkg;

	typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t; // word address on the SRAM pins
	typedef logic [`CPU_ADDR_W-1:0] cpu_addr_t; // address from the execute stage

	// one bit per byte lane, low means the lane is written
	typedef logic [`BE_W-1:0] be_n_t;

	// extension SRAM sequencing states
	typedef enum logic [1:0] {
		IDLE           = 2'd0,
		READ_EXT       = 2'd1,
		WRITE_EXT      = 2'd2,
		WRITE_EXT_HOLD = 2'd3
	} ctrl_state_t;

endpackage

/* logic/mem_access_if.sv */
`timescale 1ns/1ns

// MEM-stage access as seen by the blocks that act on it
interface mem_access_if;

	mem_op_pkg::mem_op_t op;
	mem_op_pkg::byte_sel_t byte_sel; // offset of the access inside the word
	mem_op_pkg::word_t store_data;
	sram_bus_pkg::sram_addr_t data_addr;

	// the sequencer needs the address and whether a load or store is underway
	modport fsm (
		input op,
		input data_addr
	);

	modport store (
		input op,
		input byte_sel,
		input store_data
	);

	modport load (
		input op,
		input byte_sel
	);

endinterface

/* logic/mem_req_decode.sv */
`timescale 1ns/1ns
`include "sram_params.svh"

module mem_req_decode (
	input  mem_op_pkg::mem_op_t ex_op_i,
	input  sram_bus_pkg::cpu_addr_t ex_addr_i,
	input  logic ex_tlb_miss_i,
	output logic ext_rd_o,
	output logic ext_wr_o
);

	logic is_store;
	logic misaligned;
	logic io_page;
	logic legal; // request may reach the extension SRAM

	// words need both low bits clear, halfwords only bit 0
	always_comb begin
		unique case (ex_op_i)
			mem_op_pkg::LW, mem_op_pkg::SW: misaligned = (ex_addr_i[1:0] != 2'b00);
			mem_op_pkg::LH, mem_op_pkg::LHU, mem_op_pkg::SH: misaligned = ex_addr_i[0];
			default: misaligned = 1'b0;
		endcase
	end

	assign is_store = (ex_op_i == mem_op_pkg::SB) || (ex_op_i == mem_op_pkg::SH) ||
		(ex_op_i == mem_op_pkg::SW);

	// the I/O page is served elsewhere and must never touch the SRAM
	assign io_page = (ex_addr_i[`CPU_ADDR_W-1:8] == `IO_PAGE);

	assign legal = (ex_op_i != mem_op_pkg::NOP) && !misaligned && !ex_tlb_miss_i && !io_page;

	assign ext_wr_o = legal && is_store;
	assign ext_rd_o = legal && !is_store; // every surviving non-store is a load

endmodule

/* logic/ext_sram_fsm.sv */
`timescale 1ns/1ns

module ext_sram_fsm (
	input  logic clk,
	input  logic rst,
	input  logic ext_rd_i,
	input  logic ext_wr_i,
	mem_access_if.fsm acc,
	output sram_bus_pkg::sram_addr_t ext_addr_o,
	output logic ext_we_n_o,
	output logic ext_ce_n_o,
	output logic ext_oe_n_o,
	output logic write_phase_o,
	output logic read_phase_o,
	output logic pause_o
);

	sram_bus_pkg::ctrl_state_t state;
	sram_bus_pkg::ctrl_state_t state_nxt;
	logic op_is_store;
	logic op_is_load;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sram_bus_pkg::IDLE;
		end else begin
			state <= state_nxt;
		end
	end

	// a new request is taken in every state except the write strobe,
	// where the pause holds the execute stage still
	always_comb begin
		state_nxt = sram_bus_pkg::IDLE;
		unique case (state)
			sram_bus_pkg::WRITE_EXT: state_nxt = sram_bus_pkg::WRITE_EXT_HOLD;
			default: begin
				if (ext_rd_i) begin
					state_nxt = sram_bus_pkg::READ_EXT; // reads win over writes
				end else if (ext_wr_i) begin
					state_nxt = sram_bus_pkg::WRITE_EXT;
				end
			end
		endcase
	end

	// chip controls are decoded straight from the state
	always_comb begin
		ext_we_n_o = 1'b1;
		ext_ce_n_o = 1'b1;
		ext_oe_n_o = 1'b1;
		pause_o = 1'b0;
		unique case (state)
			sram_bus_pkg::READ_EXT: begin
				ext_ce_n_o = 1'b0;
				ext_oe_n_o = 1'b0;
			end
			sram_bus_pkg::WRITE_EXT: begin
				ext_we_n_o = 1'b0; // strobe cycle
				ext_ce_n_o = 1'b0;
				pause_o = 1'b1;
			end
			sram_bus_pkg::WRITE_EXT_HOLD: begin
				ext_ce_n_o = 1'b0; // data and enables held one more cycle after we_n rises
			end
			default: begin
			end
		endcase
	end

	assign op_is_store = (acc.op == mem_op_pkg::SB) || (acc.op == mem_op_pkg::SH) ||
		(acc.op == mem_op_pkg::SW);
	assign op_is_load = (acc.op != mem_op_pkg::NOP) && !op_is_store;

	// the phase levels also require the MEM-stage op to match the state
	assign write_phase_o = ((state == sram_bus_pkg::WRITE_EXT) ||
		(state == sram_bus_pkg::WRITE_EXT_HOLD)) && op_is_store;
	assign read_phase_o = (state == sram_bus_pkg::READ_EXT) && op_is_load;

	assign ext_addr_o = (state == sram_bus_pkg::IDLE) ? '0 : acc.data_addr;

endmodule

/* logic/store_lane_gen.sv */
`timescale 1ns/1ns

module store_lane_gen (
	mem_access_if.store acc,
	input  logic write_phase_i,
	output sram_bus_pkg::be_n_t ext_be_n_o,
	output mem_op_pkg::word_t ext_data_o,
	output logic ext_data_oe_o
);

	sram_bus_pkg::be_n_t lane_en; // active-high lanes touched by the store

	// narrow stores are copied to every lane so the enabled one sees the right bits
	always_comb begin
		unique case (acc.op)
			mem_op_pkg::SW: ext_data_o = acc.store_data;
			mem_op_pkg::SH: ext_data_o = {2{acc.store_data[15:0]}};
			mem_op_pkg::SB: ext_data_o = {4{acc.store_data[7:0]}};
			default: ext_data_o = '0;
		endcase
	end

	always_comb begin
		lane_en = '0;
		unique case (acc.op)
			mem_op_pkg::SW: lane_en = '1;
			mem_op_pkg::SH: begin
				if (acc.byte_sel == 2'd0) begin
					lane_en = 4'b0011;
				end else if (acc.byte_sel == 2'd2) begin
					lane_en = 4'b1100;
				end // odd offsets write nothing
			end
			mem_op_pkg::SB: lane_en = 4'b0001 << acc.byte_sel;
			default: begin
			end
		endcase
	end

	assign ext_be_n_o = write_phase_i ? ~lane_en : '1;
	assign ext_data_oe_o = write_phase_i; // the bus is only driven while writing

endmodule

/* logic/load_align.sv */
`timescale 1ns/1ns

module load_align (
	mem_access_if.load acc,
	input  logic read_phase_i,
	input  mem_op_pkg::word_t ext_data_i,
	output mem_op_pkg::word_t load_data_o
);

	logic [7:0] sel_byte;
	logic [15:0] sel_half;
	mem_op_pkg::word_t aligned;

	assign sel_byte = ext_data_i[acc.byte_sel*8 +: 8];

	// offset 0 takes the low half and any other offset the high half
	assign sel_half = (acc.byte_sel == 2'd0) ? ext_data_i[15:0] : ext_data_i[31:16];

	always_comb begin
		unique case (acc.op)
			mem_op_pkg::LB: begin
				aligned = {{24{sel_byte[7]}}, sel_byte};
			end
			mem_op_pkg::LBU: begin
				aligned = {24'b0, sel_byte};
			end
			mem_op_pkg::LH: begin
				aligned = {{16{sel_half[15]}}, sel_half};
			end
			mem_op_pkg::LHU: begin
				aligned = {16'b0, sel_half};
			end
			default: begin
				aligned = ext_data_i; // LW passes the word unchanged
			end
		endcase
	end

	// zero whenever no read is underway so stale bus values never leak out
	assign load_data_o = read_phase_i ? aligned : '0;

endmodule

/* logic/sram_ctrl_top.sv */
`timescale 1ns/1ns

module sram_ctrl_top (
	input  logic clk,
	input  logic rst,
	input  sram_bus_pkg::sram_addr_t inst_addr_i,
	input  sram_bus_pkg::sram_addr_t data_addr_i,
	input  mem_op_pkg::word_t store_data_i,
	input  mem_op_pkg::mem_op_t ram_op_i,
	input  mem_op_pkg::byte_sel_t byte_sel_i,
	input  mem_op_pkg::mem_op_t ex_op_i,
	input  sram_bus_pkg::cpu_addr_t ex_addr_i,
	input  logic ex_tlb_miss_i,
	input  mem_op_pkg::word_t base_data_i,
	input  mem_op_pkg::word_t ext_data_i,
	output mem_op_pkg::word_t load_inst_o,
	output mem_op_pkg::word_t load_data_o,
	output sram_bus_pkg::sram_addr_t base_addr_o,
	output logic base_we_n_o,
	output logic base_ce_n_o,
	output logic base_oe_n_o,
	output sram_bus_pkg::be_n_t base_be_n_o,
	output sram_bus_pkg::sram_addr_t ext_addr_o,
	output logic ext_we_n_o,
	output logic ext_ce_n_o,
	output logic ext_oe_n_o,
	output sram_bus_pkg::be_n_t ext_be_n_o,
	output mem_op_pkg::word_t ext_data_o,
	output logic ext_data_oe_o,
	output logic pause_o
);

	logic ext_rd;
	logic ext_wr;
	logic write_phase;
	logic read_phase;

	mem_access_if acc ();

	assign acc.op = ram_op_i;
	assign acc.byte_sel = byte_sel_i;
	assign acc.store_data = store_data_i;
	assign acc.data_addr = data_addr_i;

	// the base SRAM only serves instruction fetch and stays in read mode
	assign base_addr_o = inst_addr_i;
	assign load_inst_o = base_data_i;
	assign base_we_n_o = 1'b1;
	assign base_ce_n_o = 1'b0;
	assign base_oe_n_o = 1'b0;
	assign base_be_n_o = '0;

	mem_req_decode u_decode (
		.ex_op_i       (ex_op_i),
		.ex_addr_i     (ex_addr_i),
		.ex_tlb_miss_i (ex_tlb_miss_i),
		.ext_rd_o      (ext_rd),
		.ext_wr_o      (ext_wr)
	);

	ext_sram_fsm u_fsm (
		.clk           (clk),
		.rst           (rst),
		.ext_rd_i      (ext_rd),
		.ext_wr_i      (ext_wr),
		.acc           (acc.fsm),
		.ext_addr_o    (ext_addr_o),
		.ext_we_n_o    (ext_we_n_o),
		.ext_ce_n_o    (ext_ce_n_o),
		.ext_oe_n_o    (ext_oe_n_o),
		.write_phase_o (write_phase),
		.read_phase_o  (read_phase),
		.pause_o       (pause_o)
	);

	store_lane_gen u_store (
		.acc           (acc.store),
		.write_phase_i (write_phase),
		.ext_be_n_o    (ext_be_n_o),
		.ext_data_o    (ext_data_o),
		.ext_data_oe_o (ext_data_oe_o)
	);

	load_align u_load (
		.acc          (acc.load),
		.read_phase_i (read_phase),
		.ext_data_i   (ext_data_i),
		.load_data_o  (load_data_o)
	);

endmodule

/* tests/sram_ctrl_props.sv */
`timescale 1ns/1ns
`include "sram_params.svh"

module sram_ctrl_props (
	input logic clk,
	input logic rst,
	input sram_bus_pkg::sram_addr_t inst_addr_i,
	input sram_bus_pkg::sram_addr_t base_addr_o,
	input mem_op_pkg::word_t base_data_i,
	input mem_op_pkg::word_t load_inst_o,
	input logic base_we_n_o,
	input logic base_ce_n_o,
	input logic base_oe_n_o,
	input sram_bus_pkg::be_n_t base_be_n_o,
	input mem_op_pkg::mem_op_t ex_op_i,
	input sram_bus_pkg::cpu_addr_t ex_addr_i,
	input logic ex_tlb_miss_i,
	input mem_op_pkg::mem_op_t ram_op_i,
	input mem_op_pkg::byte_sel_t byte_sel_i,
	input sram_bus_pkg::sram_addr_t data_addr_i,
	input mem_op_pkg::word_t store_data_i,
	input mem_op_pkg::word_t ext_data_i,
	input mem_op_pkg::word_t load_data_o,
	input sram_bus_pkg::sram_addr_t ext_addr_o,
	input logic ext_we_n_o,
	input logic ext_ce_n_o,
	input logic ext_oe_n_o,
	input sram_bus_pkg::be_n_t ext_be_n_o,
	input mem_op_pkg::word_t ext_data_o,
	input logic ext_data_oe_o,
	input logic pause_o
);

	int err_count = 0;

	function automatic logic legal_req(mem_op_pkg::mem_op_t op, sram_bus_pkg::cpu_addr_t a,
			logic tlb);
		logic bad;
		bad = tlb || (a[31:8] == `IO_PAGE) || (op == mem_op_pkg::NOP);
		if ((op == mem_op_pkg::LW || op == mem_op_pkg::SW) && a[1:0] != 2'b00) bad = 1'b1;
		if ((op == mem_op_pkg::LH || op == mem_op_pkg::LHU || op == mem_op_pkg::SH) && a[0])
			bad = 1'b1;
		return !bad;
	endfunction

	function automatic logic is_store(mem_op_pkg::mem_op_t op);
		return op inside {mem_op_pkg::SB, mem_op_pkg::SH, mem_op_pkg::SW};
	endfunction

	function automatic sram_bus_pkg::be_n_t exp_be_n(mem_op_pkg::mem_op_t op, logic [1:0] sel);
		case (op)
			mem_op_pkg::SW: return 4'b0000;
			mem_op_pkg::SH: return (sel == 2'd0) ? 4'b1100 : ((sel == 2'd2) ? 4'b0011 : 4'b1111);
			mem_op_pkg::SB: return ~(4'b0001 << sel);
			default: return 4'b1111;
		endcase
	endfunction

	function automatic mem_op_pkg::word_t exp_wdata(mem_op_pkg::mem_op_t op, mem_op_pkg::word_t d);
		case (op)
			mem_op_pkg::SW: return d;
			mem_op_pkg::SH: return {d[15:0], d[15:0]};
			mem_op_pkg::SB: return {d[7:0], d[7:0], d[7:0], d[7:0]};
			default: return '0;
		endcase
	endfunction

	function automatic mem_op_pkg::word_t exp_load(mem_op_pkg::mem_op_t op, logic [1:0] sel,
			mem_op_pkg::word_t w);
		logic [7:0] b;
		logic [15:0] h;
		case (sel)
			2'd0: b = w[7:0];
			2'd1: b = w[15:8];
			2'd2: b = w[23:16];
			default: b = w[31:24];
		endcase
		case (sel)
			2'd0: h = w[15:0];
			default: h = w[31:16]; // any nonzero offset takes the upper half
		endcase
		case (op)
			mem_op_pkg::LB: return {{24{b[7]}}, b};
			mem_op_pkg::LBU: return {24'd0, b};
			mem_op_pkg::LH: return {{16{h[15]}}, h};
			mem_op_pkg::LHU: return {16'd0, h};
			default: return w;
		endcase
	endfunction

	a_reset: assert property (@(posedge clk) rst |=> (ext_we_n_o && ext_ce_n_o && ext_oe_n_o &&
		ext_be_n_o == 4'hf && !ext_data_oe_o && !pause_o && load_data_o == '0))
	else begin
		$error("extension controls were not idle after reset");
		err_count++;
	end

	a_fetch: assert property (@(posedge clk) base_addr_o == inst_addr_i && load_inst_o == base_data_i)
	else begin
		$error("error base_addr_o %h load_inst_o %h expected %h %h", $sampled(base_addr_o),
			$sampled(load_inst_o), $sampled(inst_addr_i), $sampled(base_data_i));
		err_count++;
	end

	a_base_ctrl: assert property (@(posedge clk) base_we_n_o && !base_ce_n_o && !base_oe_n_o &&
		base_be_n_o == 4'h0)
	else begin
		$error("base SRAM controls left their fixed read setting");
		err_count++;
	end

	// the data address reaches the pins only while the chip is selected
	a_ext_addr: assert property (@(posedge clk) disable iff (rst)
		ext_addr_o == (ext_ce_n_o ? '0 : data_addr_i))
	else begin
		$error("error ext_addr_o %h expected %h", $sampled(ext_addr_o),
			$sampled(ext_ce_n_o) ? '0 : $sampled(data_addr_i));
		err_count++;
	end

	// a store is only taken outside the strobe cycle, which is the only one with pause high
	a_store_seq: assert property (@(posedge clk) disable iff (rst)
		(!pause_o && is_store(ex_op_i) && legal_req(ex_op_i, ex_addr_i, ex_tlb_miss_i)) |=>
		(!ext_we_n_o && !ext_ce_n_o && pause_o) ##1 (ext_we_n_o && !ext_ce_n_o && !pause_o))
	else begin
		$error("store did not produce a strobe cycle followed by a hold cycle");
		err_count++;
	end

	a_store_lanes: assert property (@(posedge clk) disable iff (rst) !ext_we_n_o |->
		ext_be_n_o == exp_be_n(ram_op_i, byte_sel_i) && ext_data_oe_o &&
		ext_data_o == exp_wdata(ram_op_i, store_data_i))
	else begin
		$error("error ext_be_n_o %h ext_data_o %h expected %h %h", $sampled(ext_be_n_o),
			$sampled(ext_data_o), exp_be_n($sampled(ram_op_i), $sampled(byte_sel_i)),
			exp_wdata($sampled(ram_op_i), $sampled(store_data_i)));
		err_count++;
	end

	a_store_hold: assert property (@(posedge clk) disable iff (rst) pause_o |=>
		$stable(ext_be_n_o) && $stable(ext_data_o))
	else begin
		$error("byte enables or store data changed between strobe and hold");
		err_count++;
	end

	// a legal load is read in the very next cycle without pausing the pipeline
	a_load_seq: assert property (@(posedge clk) disable iff (rst)
		(!pause_o && !is_store(ex_op_i) && legal_req(ex_op_i, ex_addr_i, ex_tlb_miss_i)) |=>
		(!ext_ce_n_o && !ext_oe_n_o && ext_we_n_o && !pause_o && !ext_data_oe_o))
	else begin
		$error("a legal load did not produce a read cycle");
		err_count++;
	end

	a_load: assert property (@(posedge clk) disable iff (rst) !ext_oe_n_o |-> !pause_o &&
		load_data_o == exp_load(ram_op_i, byte_sel_i, ext_data_i))
	else begin
		$error("error load_data_o %h expected %h", $sampled(load_data_o),
			exp_load($sampled(ram_op_i), $sampled(byte_sel_i), $sampled(ext_data_i)));
		err_count++;
	end

	a_suppress: assert property (@(posedge clk) disable iff (rst) (!pause_o &&
		ex_op_i != mem_op_pkg::NOP && !legal_req(ex_op_i, ex_addr_i, ex_tlb_miss_i)) |=>
		ext_ce_n_o && !pause_o)
	else begin
		$error("a rejected request still reached the extension SRAM");
		err_count++;
	end

endmodule

/* tests/sram_ctrl_tb.sv */
`timescale 1ns/1ns

module sram_ctrl_tb;

	localparam int PLANNED_OPS = 76; // operations issued by all tests together
	localparam int RESET_CYCLES = 10;

	logic clk = 1'b0;
	logic rst;
	sram_bus_pkg::sram_addr_t inst_addr_i;
	sram_bus_pkg::sram_addr_t data_addr_i;
	sram_bus_pkg::sram_addr_t base_addr_o;
	sram_bus_pkg::sram_addr_t ext_addr_o;
	mem_op_pkg::word_t store_data_i;
	mem_op_pkg::word_t base_data_i;
	mem_op_pkg::word_t ext_data_i;
	mem_op_pkg::word_t load_inst_o;
	mem_op_pkg::word_t load_data_o;
	mem_op_pkg::word_t ext_data_o;
	mem_op_pkg::mem_op_t ram_op_i;
	mem_op_pkg::mem_op_t ex_op_i;
	mem_op_pkg::byte_sel_t byte_sel_i;
	sram_bus_pkg::cpu_addr_t ex_addr_i;
	logic ex_tlb_miss_i;
	logic base_we_n_o;
	logic base_ce_n_o;
	logic base_oe_n_o;
	sram_bus_pkg::be_n_t base_be_n_o;
	sram_bus_pkg::be_n_t ext_be_n_o;
	logic ext_we_n_o;
	logic ext_ce_n_o;
	logic ext_oe_n_o;
	logic ext_data_oe_o;
	logic pause_o;

	mem_op_pkg::word_t mem [16]; // extension SRAM model
	mem_op_pkg::word_t ref_mem [16]; // what the memory should hold once stores land
	mem_op_pkg::word_t ex_data;
	logic ex_legal;
	logic pause_prev;
	integer seed;
	int tb_errs = 0;
	int errs_seen = 0;
	int tests_run = 0;
	int r;

	always #20 clk = ~clk;

	sram_ctrl_top dut0 (.*);

	always @(posedge clk) begin
		if (!ext_we_n_o && !ext_ce_n_o) begin
			for (int l = 0; l < 4; l++) begin
				if (!ext_be_n_o[l]) mem[ext_addr_o[3:0]][l*8 +: 8] <= ext_data_o[l*8 +: 8];
			end
		end
	end

	assign ext_data_i = mem[ext_addr_o[3:0]];

	// every read must see the word merged from all earlier stores
	always @(posedge clk) begin
		if (!rst && !ext_oe_n_o) begin
			assert (ext_data_i == ref_mem[ext_addr_o[3:0]]) else begin
				$display("error ext_data_i %h expected %h", ext_data_i, ref_mem[ext_addr_o[3:0]]);
				tb_errs++;
			end
		end
	end

	function automatic mem_op_pkg::word_t fetch_word(sram_bus_pkg::sram_addr_t a);
		return {~a[11:0], a};
	endfunction

	function automatic mem_op_pkg::word_t merge_store(mem_op_pkg::word_t old,
			mem_op_pkg::mem_op_t op, logic [1:0] sel, mem_op_pkg::word_t d);
		case (op)
			mem_op_pkg::SW: old = d;
			mem_op_pkg::SH: begin
				if (sel == 2'd0) old[15:0] = d[15:0];
				else if (sel == 2'd2) old[31:16] = d[15:0];
			end
			mem_op_pkg::SB: old[sel*8 +: 8] = d[7:0];
			default: begin
			end
		endcase
		return old;
	endfunction

	function automatic int total_errs();
		return dut0.props0.err_count + tb_errs;
	endfunction

	// one pipeline step; the stages hold while the previous cycle paused
	task automatic issue_op(input mem_op_pkg::mem_op_t op, input sram_bus_pkg::cpu_addr_t addr,
			input logic tlb, input mem_op_pkg::word_t data, input logic legal);
		logic stall;
		int fr;
		do begin
			@(negedge clk);
			fr = $random(seed);
			inst_addr_i = fr[19:0];
			base_data_i = fetch_word(inst_addr_i);
			stall = pause_prev;
			pause_prev = pause_o;
		end while (stall);
		ram_op_i = ex_op_i;
		data_addr_i = ex_addr_i[21:2];
		byte_sel_i = ex_addr_i[1:0];
		store_data_i = ex_data;
		if (ex_legal) ref_mem[ex_addr_i[5:2]] = merge_store(ref_mem[ex_addr_i[5:2]], ex_op_i,
			ex_addr_i[1:0], ex_data);
		ex_op_i = op;
		ex_addr_i = addr;
		ex_tlb_miss_i = tlb;
		ex_data = data;
		ex_legal = legal;
	endtask

	task automatic drain();
		repeat (3) issue_op(mem_op_pkg::NOP, '0, 1'b0, '0, 1'b0);
	endtask

	task automatic report(input string name);
		int now_errs;
		drain();
		now_errs = total_errs();
		$display("%s: %0d failing checks", name, now_errs - errs_seen);
		errs_seen = now_errs;
		tests_run++;
	endtask

	initial begin
		seed = 32'h554d4e4b;
		rst = 1'b1;
		inst_addr_i = '0;
		base_data_i = fetch_word('0);
		data_addr_i = '0;
		store_data_i = '0;
		ram_op_i = mem_op_pkg::NOP;
		byte_sel_i = '0;
		ex_op_i = mem_op_pkg::NOP;
		ex_addr_i = '0;
		ex_tlb_miss_i = 1'b0;
		ex_data = '0;
		ex_legal = 1'b0;
		pause_prev = 1'b0;
		for (int i = 0; i < 16; i++) begin
			ref_mem[i] = 32'h9e3779b9 * (i + 1);
			mem[i] <= ref_mem[i];
		end
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		report("reset");

		repeat (20) issue_op(mem_op_pkg::NOP, '0, 1'b0, '0, 1'b0);
		report("instruction fetch");

		for (int n = 0; n < 12; n++) begin
			r = $random(seed);
			case (r[9:8])
				2'd0: issue_op(mem_op_pkg::SW, {26'd0, r[3:0], 2'd0}, 1'b0, $random(seed), 1'b1);
				2'd1: issue_op(mem_op_pkg::SH, {26'd0, r[3:0], r[6], 1'b0}, 1'b0, $random(seed), 1'b1);
				default: issue_op(mem_op_pkg::SB, {26'd0, r[3:0], r[7:6]}, 1'b0, $random(seed), 1'b1);
			endcase
			issue_op(mem_op_pkg::LW, {26'd0, r[3:0], 2'd0}, 1'b0, '0, 1'b1); // read back merged word
		end
		report("store");

		for (int o = 0; o < 4; o++) begin
			r = $random(seed);
			issue_op(mem_op_pkg::LB, {26'd0, r[3:0], o[1:0]}, 1'b0, '0, 1'b1);
			issue_op(mem_op_pkg::LBU, {26'd0, r[7:4], o[1:0]}, 1'b0, '0, 1'b1);
			if (o[0] == 1'b0) begin
				issue_op(mem_op_pkg::LH, {26'd0, r[11:8], o[1:0]}, 1'b0, '0, 1'b1);
				issue_op(mem_op_pkg::LHU, {26'd0, r[15:12], o[1:0]}, 1'b0, '0, 1'b1);
			end
		end
		issue_op(mem_op_pkg::LW, {26'd0, 4'd9, 2'd0}, 1'b0, '0, 1'b1);
		report("load");

		issue_op(mem_op_pkg::LW, 32'h0000_0011, 1'b0, '0, 1'b0); // misaligned word
		issue_op(mem_op_pkg::SH, 32'h0000_0023, 1'b0, 32'hdead_beef, 1'b0);
		issue_op(mem_op_pkg::LW, 32'h0000_0004, 1'b1, '0, 1'b0);
		issue_op(mem_op_pkg::LW, 32'hbfd0_0310, 1'b0, '0, 1'b0); // I/O page
		report("suppression");

		$display("tests run %0d, failing checks %0d", tests_run, total_errs());
		if (total_errs() == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	initial begin
		#((PLANNED_OPS * 4 + RESET_CYCLES) * 40);
		$display("timeout, the tests did not finish in the expected time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

bind sram_ctrl_top sram_ctrl_props props0 (.*);

/* tb.f */
+incdir+logic
logic/mem_op_pkg.sv
logic/sram_bus_pkg.sv
logic/mem_access_if.sv
logic/mem_req_decode.sv
logic/ext_sram_fsm.sv
logic/store_lane_gen.sv
logic/load_align.sv
logic/sram_ctrl_top.sv
tests/sram_ctrl_props.sv
tests/sram_ctrl_tb.sv

/* Makefile */
TOP = sram_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim +verilator+error+limit+1000); echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir
